// File: dv/tb_weight_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "wcache_config.svh"

module tb_weight_cache
    import wcache_types_pkg::*;
();

    localparam int NP      = `WC_NUM_PORTS;
    localparam int TIMEOUT = 4000;  // Six short tests finish well under this

    logic clk;
    logic rst_n;
    logic cfg_vld;
    logic cfg_rdy;
    logic cfg_cache_en;
    port_mask_t req_vld;
    port_mask_t req_rdy;
    wram_addr_t [NP-1:0] req_addr;
    port_mask_t req_last;
    port_mask_t rsp_vld;
    port_mask_t rsp_rdy;
    weight_t [NP-1:0] rsp_data;
    port_mask_t rsp_last;
    logic wram_addr_vld;
    logic wram_addr_rdy;
    wram_addr_t wram_addr;
    logic wram_data_vld;
    logic wram_data_rdy;
    weight_t wram_data;

    // Per-port request lists and progress
    wram_addr_t list_addr [NP][64];
    logic       list_last [NP][64];
    int req_cnt [NP];
    int req_pos [NP];
    int rsp_pos [NP];

    int seed = 32'h34ee_4999;
    int errors;
    int tests;
    int cycles;
    int reads;          // Weight RAM address handshakes
    logic       m_pend;
    logic [2:0] m_cnt;
    wram_addr_t m_addr;
    logic       held [NP];
    weight_t    held_data [NP];

    weight_cache_top weight_cache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Run stopped after %0d cycles, responses never completed", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================
    // Weight RAM model
    // ========================================
    always @(posedge clk) begin
        int dly;
        int stall;
        if (!rst_n) begin
            m_pend        <= 1'b0;
            wram_data_vld <= 1'b0;
            wram_addr_rdy <= 1'b1;
        end else begin
            stall = $random(seed);
            wram_addr_rdy <= (stall[1:0] != 2'b00);  // Refuse about one cycle in four
            if (wram_data_vld && wram_data_rdy) begin
                wram_data_vld <= 1'b0;
            end
            if (wram_addr_vld && wram_addr_rdy) begin
                dly = $random(seed);
                reads++;
                m_addr <= wram_addr;
                m_cnt  <= {1'b0, dly[1:0]} + 3'd1;  // 1 to 4 cycles
                m_pend <= 1'b1;
            end else if (m_pend) begin
                if (m_cnt == 3'd1) begin
                    wram_data_vld <= 1'b1;
                    wram_data     <= m_addr[7:0] ^ 8'h5a;
                    m_pend        <= 1'b0;
                end else begin
                    m_cnt <= m_cnt - 3'd1;
                end
            end
        end
    end

    // Request drivers and response checkers
    always @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (rst_n && (!req_vld[p] || req_rdy[p])) begin
                if (req_pos[p] < req_cnt[p]) begin
                    req_vld[p]  <= 1'b1;
                    req_addr[p] <= list_addr[p][req_pos[p]];
                    req_last[p] <= list_last[p][req_pos[p]];
                    req_pos[p]  =  req_pos[p] + 1;
                end else begin
                    req_vld[p] <= 1'b0;
                end
            end
            if (rsp_vld[p] && rsp_rdy[p]) begin
                assert (rsp_data[p] == (list_addr[p][rsp_pos[p]][7:0] ^ 8'h5a)) else begin
                    $display("FAILED at %0t: rsp_data[%0d] got %h expected %h", $time, p,
                             rsp_data[p], list_addr[p][rsp_pos[p]][7:0] ^ 8'h5a);
                    errors++;
                end
                assert (rsp_last[p] == list_last[p][rsp_pos[p]]) else begin
                    $display("FAILED at %0t: rsp_last[%0d] got %b expected %b", $time, p,
                             rsp_last[p], list_last[p][rsp_pos[p]]);
                    errors++;
                end
                rsp_pos[p]++;
            end
            // A stalled response must not move
            if (held[p]) begin
                assert (rsp_vld[p]) else begin
                    $display("FAILED at %0t: rsp_vld[%0d] got 0 expected 1", $time, p);
                    errors++;
                end
                assert (rsp_data[p] == held_data[p]) else begin
                    $display("FAILED at %0t: rsp_data[%0d] got %h expected %h", $time, p,
                             rsp_data[p], held_data[p]);
                    errors++;
                end
            end
            held[p]      = rsp_vld[p] && !rsp_rdy[p];
            held_data[p] = rsp_data[p];
        end
    end

    task automatic queue_req(input int p, input wram_addr_t a, input logic l);
        list_addr[p][req_cnt[p]] = a;
        list_last[p][req_cnt[p]] = l;
        req_cnt[p]++;
    endtask

    task automatic wait_responses();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = 1'b1;
            for (int p = 0; p < NP; p++) begin
                if (rsp_pos[p] != req_cnt[p]) done = 1'b0;
            end
        end
    endtask

    task automatic configure(input logic cache_en);
        @(posedge clk);
        cfg_vld      <= 1'b1;
        cfg_cache_en <= cache_en;
        do @(posedge clk); while (!cfg_rdy);
        cfg_vld <= 1'b0;
        @(negedge clk);
        assert (!cfg_rdy) else begin
            $display("FAILED at %0t: cfg_rdy got 1 expected 0", $time);
            errors++;
        end
        repeat (2) @(posedge clk);  // WORK two cycles after the handshake
    endtask

    task automatic go_idle();
        @(posedge clk);
        cfg_vld <= 1'b1;
        @(posedge clk);
        cfg_vld <= 1'b0;
        @(negedge clk);
        assert (cfg_rdy) else begin
            $display("FAILED at %0t: cfg_rdy got 0 expected 1", $time);
            errors++;
        end
    endtask

    task automatic check_reads(input int got, input int exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: read count got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic cfg_test();
        int e0;
        e0 = errors;
        assert (cfg_rdy) else begin
            $display("FAILED at %0t: cfg_rdy got 0 expected 1", $time);
            errors++;
        end
        configure(1'b0);
        go_idle();
        report("config handshake", e0);
    endtask

    task automatic bypass_test();
        int e0;
        int r0;
        e0 = errors;
        configure(1'b0);
        r0 = reads;
        @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            for (int i = 0; i < 5; i++) begin
                queue_req(p, wram_addr_t'(13'h400 + p * 64 + i * 5), i[0]);
            end
        end
        wait_responses();
        check_reads(reads - r0, 5 * NP);
        report("bypass reads", e0);
    endtask

    task automatic hit_test();
        int e0;
        int r0;
        e0 = errors;
        go_idle();
        configure(1'b1);
        r0 = reads;
        @(negedge clk);
        for (int i = 0; i < 16; i++) begin
            queue_req(0, wram_addr_t'(13'h100 + (i % 8) * 3), i % 8 == 7);
        end
        wait_responses();
        check_reads(reads - r0, 8);
        report("cache hits", e0);
    endtask

    task automatic shared_test();
        int e0;
        int r0;
        e0 = errors;
        r0 = reads;
        @(negedge clk);
        for (int p = 0; p < NP; p++) queue_req(p, 13'h0777, 1'b1);
        wait_responses();
        check_reads(reads - r0, 1);
        report("shared read", e0);
    endtask

    task automatic stall_test();
        int e0;
        int n0;
        e0 = errors;
        @(posedge clk);
        rsp_rdy[1] <= 1'b0;
        @(negedge clk);
        n0 = rsp_pos[1];
        queue_req(1, 13'h00a5, 1'b0);
        queue_req(1, 13'h00a5, 1'b1);  // Hit behind the stalled miss
        queue_req(1, 13'h01b3, 1'b1);
        queue_req(0, 13'h00c1, 1'b1);
        while (!rsp_vld[1]) @(negedge clk);
        repeat (6) @(negedge clk);     // Keep the first response waiting
        assert (rsp_vld[1]) else begin
            $display("FAILED at %0t: rsp_vld[1] got 0 expected 1", $time);
            errors++;
        end
        assert (rsp_data[1] == (list_addr[1][n0][7:0] ^ 8'h5a)) else begin
            $display("FAILED at %0t: rsp_data[1] got %h expected %h", $time, rsp_data[1],
                     list_addr[1][n0][7:0] ^ 8'h5a);
            errors++;
        end
        @(posedge clk);
        rsp_rdy[1] <= 1'b1;
        wait_responses();
        report("back-pressure", e0);
    endtask

    task automatic reconfig_test();
        int e0;
        int r0;
        e0 = errors;
        go_idle();
        configure(1'b1);
        r0 = reads;
        @(negedge clk);
        queue_req(2, 13'h0100, 1'b1);
        wait_responses();
        check_reads(reads - r0, 1);
        report("reconfig flush", e0);
    endtask

    initial begin
        rst_n         = 1'b0;
        cfg_vld       = 1'b0;
        cfg_cache_en  = 1'b0;
        req_vld       = '0;
        req_addr      = '0;
        req_last      = '0;
        rsp_rdy       = '1;
        wram_addr_rdy = 1'b1;
        wram_data_vld = 1'b0;
        wram_data     = '0;
        for (int p = 0; p < NP; p++) begin
            req_cnt[p] = 0;
            req_pos[p] = 0;
            rsp_pos[p] = 0;
            held[p]    = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        cfg_test();
        bypass_test();
        hit_test();
        shared_test();
        stall_test();
        reconfig_test();
        $display("Tests %0d, errors %0d, weight RAM reads %0d", tests, errors, reads);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/wcache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_properties
    import wcache_types_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       addr_vld,
    input wire logic       addr_rdy,
    input wire wram_addr_t addr,
    input wire logic       data_vld,
    input wire logic       data_rdy,
    input wire logic       ret_fire,
    input wire wram_addr_t ret_addr
);

    logic       rd_open;    // Address taken, data not yet taken
    wram_addr_t open_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_open   <= 1'b0;
            open_addr <= '0;
        end else if (addr_vld && addr_rdy) begin
            rd_open   <= 1'b1;
            open_addr <= addr;
        end else if (data_vld && data_rdy) begin
            rd_open <= 1'b0;
        end
    end

    // Address channel holds until accepted
    addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        addr_vld && !addr_rdy |=> addr_vld && $stable(addr))
        else $error("weight RAM address dropped or changed before ready");

    // Only one read in flight
    one_read: assert property (@(posedge clk) disable iff (!rst_n)
        addr_vld && addr_rdy |-> !rd_open)
        else $error("address handshake while a read is outstanding");

    data_open: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy |-> rd_open)
        else $error("weight RAM data accepted with no read outstanding");

    // Return carries the address of the read it answers
    return_open: assert property (@(posedge clk) disable iff (!rst_n)
        ret_fire |-> rd_open && ret_addr == open_addr)
        else $error("return fired for an address that was not read");

endmodule

bind port_arbiter wcache_properties wcache_properties_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_vld (wram_addr_vld),
    .addr_rdy (wram_addr_rdy),
    .addr     (wram_addr),
    .data_vld (wram_data_vld),
    .data_rdy (wram_data_rdy),
    .ret_fire (ret.fire),
    .ret_addr (ret.addr)
);

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the weight cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_weight_cache

out=$(./obj_dir/Vtb_weight_cache)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

// File: verilog.f
+incdir+verilog
verilog/wcache_types_pkg.sv
verilog/wcache_ctrl_pkg.sv
verilog/rd_return_if.sv
verilog/wcache_ctrl.sv
verilog/port_arbiter.sv
verilog/hit_store.sv
verilog/port_resp.sv
verilog/weight_cache_top.sv
dv/wcache_properties.sv
dv/tb_weight_cache.sv

// File: verilog/hit_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "wcache_config.svh"

module hit_store
    import wcache_types_pkg::*;
    import wcache_ctrl_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              working,
    input  wc_mode_e                          mode,
    input  port_mask_t                        req_vld,
    input  wram_addr_t [`WC_NUM_PORTS-1:0]    req_addr,
    rd_return_if.sink                         ret,
    output port_mask_t                        hit,
    output weight_t    [`WC_NUM_PORTS-1:0]    hit_data
);

    wram_addr_t slot_addr [`WC_SLOTS];
    weight_t    slot_data [`WC_SLOTS];
    slot_mask_t slot_vld;
    slot_idx_t  fill_ptr;

    wram_addr_t last_addr;     // Last-access register
    weight_t    last_data;
    logic       last_vld;

    slot_mask_t ret_match;
    logic       lookup_en;
    logic       fill_en;

    assign lookup_en = working && (mode == MODE_CACHE);

    // ========================================
    // Fill on weight RAM return
    // ========================================
    always_comb begin
        for (int s = 0; s < `WC_SLOTS; s++) begin
            ret_match[s] = slot_vld[s] && (slot_addr[s] == ret.addr);
        end
    end

    // Only new addresses take a slot
    assign fill_en = lookup_en && ret.fire && !(|ret_match);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= '0;
            fill_ptr <= '0;
        end else if (!working) begin
            slot_vld <= '0;
            fill_ptr <= '0;
        end else if (fill_en) begin
            slot_vld[fill_ptr] <= 1'b1;
            fill_ptr           <= fill_ptr + 1'b1;  // Oldest slot goes next
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            slot_addr[fill_ptr] <= ret.addr;
            slot_data[fill_ptr] <= ret.data;
        end
    end

    // Every return, whether it filled a slot or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_vld <= 1'b0;
        end else if (!working) begin
            last_vld <= 1'b0;
        end else if (ret.fire) begin
            last_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ret.fire) begin
            last_addr <= ret.addr;
            last_data <= ret.data;
        end
    end

    // ========================================
    // Per-port lookup
    // ========================================
    for (genvar p = 0; p < `WC_NUM_PORTS; p++) begin : g_lookup
        slot_mask_t match;
        slot_idx_t  first;
        logic       last_hit;

        always_comb begin
            for (int s = 0; s < `WC_SLOTS; s++) begin
                match[s] = slot_vld[s] && (slot_addr[s] == req_addr[p]);
            end
        end

        // Lowest matching slot
        always_comb begin
            first = '0;
            for (int s = `WC_SLOTS - 1; s >= 0; s--) begin
                if (match[s]) begin
                    first = slot_idx_t'(s);
                end
            end
        end

        assign last_hit    = last_vld && (last_addr == req_addr[p]);
        assign hit[p]      = lookup_en && req_vld[p] && (|match || last_hit);
        assign hit_data[p] = |match ? slot_data[first] : last_data;
    end

endmodule

`default_nettype wire

// File: verilog/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "wcache_config.svh"

module port_arbiter
    import wcache_types_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              working,
    input  port_mask_t                        req_vld,
    input  port_mask_t                        hit,
    input  wram_addr_t [`WC_NUM_PORTS-1:0]    req_addr,
    input  logic                              wram_addr_rdy,
    input  logic                              wram_data_vld,
    input  weight_t                           wram_data,
    input  port_mask_t                        rsp_busy,
    output port_mask_t                        miss_taken,
    output logic                              wram_addr_vld,
    output wram_addr_t                        wram_addr,
    output logic                              wram_data_rdy,
    rd_return_if.src                          ret
);

    port_mask_t miss;
    port_mask_t share;
    port_mask_t pend_mask;      // Ports served by the outstanding read
    port_idx_t  rr_ptr;
    port_idx_t  sel_idx;
    port_idx_t  hold_idx;
    port_idx_t  cur_idx;
    logic       sel_vld;
    logic       hold_vld;       // Address presented but not yet accepted
    logic       rd_outstanding;
    logic       addr_fire;
    wram_addr_t rd_addr;

    // ========================================
    // Round-robin selection
    // ========================================

    // Busy ports wait so a held hit is not overtaken by a return
    assign miss = {`WC_NUM_PORTS{working}} & req_vld & ~hit & ~rsp_busy;

    // Scan downward so the port closest to rr_ptr wins
    always_comb begin
        sel_vld = 1'b0;
        sel_idx = rr_ptr;
        for (int k = `WC_NUM_PORTS - 1; k >= 0; k--) begin
            if (miss[port_idx_t'(rr_ptr + k)]) begin
                sel_vld = 1'b1;
                sel_idx = port_idx_t'(rr_ptr + k);
            end
        end
    end

    // Keep the address stable until it is taken
    assign cur_idx       = hold_vld ? hold_idx : sel_idx;
    assign wram_addr_vld = working && !rd_outstanding && (hold_vld || sel_vld);
    assign wram_addr     = req_addr[cur_idx];
    assign addr_fire     = wram_addr_vld && wram_addr_rdy;

    // Same-address misses ride along on the granted read
    always_comb begin
        for (int p = 0; p < `WC_NUM_PORTS; p++) begin
            share[p] = (miss[p] && (req_addr[p] == wram_addr)) || (cur_idx == port_idx_t'(p));
        end
    end

    assign miss_taken = addr_fire ? share : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
            hold_idx <= '0;
            rr_ptr   <= '0;
        end else if (!working) begin
            hold_vld <= 1'b0;
        end else if (addr_fire) begin
            hold_vld <= 1'b0;
            rr_ptr   <= cur_idx + 1'b1;
        end else if (wram_addr_vld && !hold_vld) begin
            hold_vld <= 1'b1;
            hold_idx <= sel_idx;
        end
    end

    // ========================================
    // Outstanding read and return
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_outstanding <= 1'b0;
            pend_mask      <= '0;
        end else if (!working) begin
            rd_outstanding <= 1'b0;
            pend_mask      <= '0;
        end else if (addr_fire) begin
            rd_outstanding <= 1'b1;
            pend_mask      <= share;
        end else if (ret.fire) begin
            rd_outstanding <= 1'b0;
            pend_mask      <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_fire) begin
            rd_addr <= wram_addr;
        end
    end

    // Stall the return while any destination port holds its output
    assign wram_data_rdy = rd_outstanding && !(|(pend_mask & rsp_busy));

    assign ret.fire = wram_data_vld && wram_data_rdy;
    assign ret.addr = rd_addr;
    assign ret.data = wram_data;
    assign ret.dest = wram_data_vld ? pend_mask : '0;

endmodule

`default_nettype wire

// File: verilog/port_resp.sv
`timescale 1ns/1ps
`default_nettype none

module port_resp
    import wcache_types_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             working,
    input  port_idx_t        port,
    input  logic             req_vld,
    input  logic             req_last,
    input  logic             hit,
    input  weight_t          hit_data,
    input  logic             miss_taken,
    input  logic             rsp_rdy,
    rd_return_if.sink        ret,
    output logic             req_rdy,
    output logic             rsp_vld,
    output weight_t          rsp_data,
    output logic             rsp_last,
    output logic             busy
);

    logic    ret_here;
    logic    stage_adv;
    logic    hit_acc;
    logic    hit_vld;
    weight_t hit_dat;
    logic    hit_lst;
    logic    miss_pend;   // Granted read not yet returned
    logic    miss_lst;

    assign ret_here = ret.dest[port];

    // Stage moves on when empty, or when its output is taken
    assign stage_adv = !hit_vld || (rsp_rdy && !ret_here);

    // No hit while a miss is pending, keeps responses in order
    assign hit_acc = working && req_vld && hit && !miss_pend && !ret_here && stage_adv;
    assign req_rdy = hit_acc || miss_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_vld <= 1'b0;
        end else if (!working) begin
            hit_vld <= 1'b0;
        end else if (stage_adv) begin
            hit_vld <= hit_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_acc) begin
            hit_dat <= hit_data;
            hit_lst <= req_last;
        end
        if (miss_taken) begin
            miss_lst <= req_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_pend <= 1'b0;
        end else if (!working) begin
            miss_pend <= 1'b0;
        end else if (miss_taken) begin
            miss_pend <= 1'b1;
        end else if (ret.fire && ret_here) begin
            miss_pend <= 1'b0;
        end
    end

    // Return first, then the hit stage
    assign rsp_vld  = working && (ret_here || hit_vld);
    assign rsp_data = ret_here ? ret.data : hit_dat;
    assign rsp_last = ret_here ? miss_lst : hit_lst;
    assign busy     = rsp_vld && !rsp_rdy;

endmodule

`default_nettype wire

// File: verilog/rd_return_if.sv
`timescale 1ns/1ps
`default_nettype none

// One weight RAM return, seen by the store and all port stages
interface rd_return_if
    import wcache_types_pkg::*;
();

    logic       fire;  // Data handshake this cycle
    wram_addr_t addr;  // Address of the outstanding read
    weight_t    data;
    port_mask_t dest;  // Ports waiting on this read, only while data is present

    modport src (
        output fire, addr, data, dest
    );

    modport sink (
        input fire, addr, data, dest
    );

endinterface

`default_nettype wire

// File: verilog/wcache_config.svh
`ifndef WCACHE_CONFIG_SVH
`define WCACHE_CONFIG_SVH

// ========================================
// Weight cache sizing
// ========================================

// PE read ports sharing one weight RAM
`define WC_NUM_PORTS 4

// Weight RAM address width
`define WC_ADDR_W 13

// One weight
`define WC_DATA_W 8

// Cached address/weight pairs
`define WC_SLOTS 32

`endif

// File: verilog/wcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_ctrl
    import wcache_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_vld,
    input  logic     cfg_cache_en,
    output logic     cfg_rdy,
    output logic     working,
    output wc_mode_e mode
);

    wc_state_e state;
    wc_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (cfg_vld) begin
                    state_nxt = ST_CFG;
                end
            end
            ST_CFG:  state_nxt = ST_WORK;
            ST_WORK: begin
                // New cfg request drops back to IDLE and flushes everything
                if (cfg_vld) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Mode taken when entering WORK
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_BYPASS;
        end else if (state == ST_IDLE) begin
            mode <= MODE_BYPASS;
        end else if (state == ST_CFG && state_nxt == ST_WORK) begin
            mode <= cfg_cache_en ? MODE_CACHE : MODE_BYPASS;
        end
    end

    assign cfg_rdy = (state == ST_IDLE);
    assign working = (state == ST_WORK);

endmodule

`default_nettype wire

// File: verilog/wcache_ctrl_pkg.sv
`default_nettype none

package wcache_ctrl_pkg;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_CFG  = 2'd1,
        ST_WORK = 2'd2
    } wc_state_e;

    typedef enum logic {
        MODE_BYPASS = 1'b0,  // Always read weight RAM
        MODE_CACHE  = 1'b1   // Serve hits from the store
    } wc_mode_e;

endpackage

`default_nettype wire

// File: verilog/wcache_types_pkg.sv
`default_nettype none

`include "wcache_config.svh"

package wcache_types_pkg;

    // Weight RAM address and payload
    typedef logic [`WC_ADDR_W-1:0] wram_addr_t;
    typedef logic [`WC_DATA_W-1:0] weight_t;

    // Per port
    typedef logic [`WC_NUM_PORTS-1:0]         port_mask_t;
    typedef logic [$clog2(`WC_NUM_PORTS)-1:0] port_idx_t;

    // Per cache slot
    typedef logic [$clog2(`WC_SLOTS)-1:0] slot_idx_t;
    typedef logic [`WC_SLOTS-1:0]         slot_mask_t;

endpackage

`default_nettype wire

// File: verilog/weight_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wcache_config.svh"

module weight_cache_top
    import wcache_types_pkg::*;
    import wcache_ctrl_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    // Configuration
    input  logic                              cfg_vld,
    output logic                              cfg_rdy,
    input  logic                              cfg_cache_en,
    // PE requests
    input  port_mask_t                        req_vld,
    output port_mask_t                        req_rdy,
    input  wram_addr_t [`WC_NUM_PORTS-1:0]    req_addr,
    input  port_mask_t                        req_last,
    // PE responses
    output port_mask_t                        rsp_vld,
    input  port_mask_t                        rsp_rdy,
    output weight_t    [`WC_NUM_PORTS-1:0]    rsp_data,
    output port_mask_t                        rsp_last,
    // Weight RAM read port
    output logic                              wram_addr_vld,
    input  logic                              wram_addr_rdy,
    output wram_addr_t                        wram_addr,
    input  logic                              wram_data_vld,
    output logic                              wram_data_rdy,
    input  weight_t                           wram_data
);

    logic                             working;
    wc_mode_e                         mode;
    port_mask_t                       hit;
    port_mask_t                       miss_taken;
    port_mask_t                       rsp_busy;
    weight_t    [`WC_NUM_PORTS-1:0]   hit_data;

    rd_return_if ret_if ();

    wcache_ctrl wcache_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_cache_en (cfg_cache_en),
        .cfg_rdy      (cfg_rdy),
        .working      (working),
        .mode         (mode)
    );

    hit_store hit_store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .working  (working),
        .mode     (mode),
        .req_vld  (req_vld),
        .req_addr (req_addr),
        .ret      (ret_if),
        .hit      (hit),
        .hit_data (hit_data)
    );

    port_arbiter port_arbiter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .working       (working),
        .req_vld       (req_vld),
        .hit           (hit),
        .req_addr      (req_addr),
        .wram_addr_rdy (wram_addr_rdy),
        .wram_data_vld (wram_data_vld),
        .wram_data     (wram_data),
        .rsp_busy      (rsp_busy),
        .miss_taken    (miss_taken),
        .wram_addr_vld (wram_addr_vld),
        .wram_addr     (wram_addr),
        .wram_data_rdy (wram_data_rdy),
        .ret           (ret_if)
    );

    // One response stage per PE port
    for (genvar p = 0; p < `WC_NUM_PORTS; p++) begin : g_port
        port_resp port_resp_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .working    (working),
            .port       (port_idx_t'(p)),
            .req_vld    (req_vld[p]),
            .req_last   (req_last[p]),
            .hit        (hit[p]),
            .hit_data   (hit_data[p]),
            .miss_taken (miss_taken[p]),
            .rsp_rdy    (rsp_rdy[p]),
            .ret        (ret_if),
            .req_rdy    (req_rdy[p]),
            .rsp_vld    (rsp_vld[p]),
            .rsp_data   (rsp_data[p]),
            .rsp_last   (rsp_last[p]),
            .busy       (rsp_busy[p])
        );
    end

endmodule

`default_nettype wire
